/* list.f */
+incdir+sim
src/dur_pkg.sv
src/basic_rate_sel.sv
src/rate_table_rd.sv
src/frame_airtime.sv
src/dur_ctrl.sv
src/tx_duration.sv
sim/tb_tx_duration.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the tx_duration testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -f list.f --top-module tb_tx_duration -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_tx_duration > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Test passed" "$LOG"; then
	exit 0
else
	echo "pass message not found in $LOG"
	exit 1
fi

/* sim/tb_dur_model.svh */
`ifndef TB_DUR_MODEL_SVH
`define TB_DUR_MODEL_SVH

typedef struct packed {
	logic                 busy;     // pulse a second start mid-request
	dur_kind_t            kind;
	rate_code_t           code;
	resp_len_t            resp_len;
	frame_len_t           next_len;
	logic                 long_pre;
	logic [NUM_RATES-1:0] brs;
	dur_t                 sifs;
	dur_t                 exp_dur;
	rate_idx_t            exp_rate;
} row_t;

// ceil(256 / bits per symbol) for OFDM, ceil(256 / Mb/s) for CCK
logic [15:0] inv_tab [NUM_RATES] = '{
	16'd256, 16'd128, 16'd47, 16'd24,
	16'd11, 16'd8, 16'd6, 16'd4, 16'd3, 16'd2, 16'd2, 16'd2
};

logic [15:0] lfsr_q = 16'd5;

function automatic logic lfsr_bit();
	logic b;
	b = lfsr_q[0];
	lfsr_q = lfsr_q >> 1;
	if (b)
		lfsr_q = lfsr_q ^ 16'hB400; // galois taps 16,14,13,11
	return b;
endfunction

function automatic logic [15:0] rand_bits(input int n);
	logic [15:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
		v = {v[14:0], lfsr_bit()};
	return v;
endfunction

function automatic rate_idx_t idx_of_code(input rate_code_t c);
	case (c)
		4'd8: return 4'd0;
		4'd9: return 4'd1;
		4'd10: return 4'd2;
		4'd11: return 4'd3;
		4'd3: return 4'd4;
		4'd7: return 4'd5;
		4'd2: return 4'd6;
		4'd6: return 4'd7;
		4'd1: return 4'd8;
		4'd5: return 4'd9;
		4'd0: return 4'd10;
		default: return 4'd11;
	endcase
endfunction

// walk down from the data rate, stop at the class floor
function automatic rate_idx_t pick_basic(input rate_idx_t d, input logic [NUM_RATES-1:0] brs);
	int lo;
	int pick;
	lo = (int'(d) < 4) ? 0 : 4;
	pick = lo;
	for (int i = lo; i <= int'(d); i++)
		if (brs[i])
			pick = i;
	return rate_idx_t'(pick);
endfunction

function automatic int airtime(input int len, input rate_idx_t idx, input logic lp);
	int inv;
	int nsym;
	inv = int'(inv_tab[idx]);
	if (int'(idx) < 4)
		return (inv * 8 * len + 255) / 256 + (lp ? 192 : 96);
	nsym = (inv * (16 + 8 * len + 6) + 255) / 256;
	return 16 + 4 + 4 * nsym + 6;
endfunction

function automatic dur_t model_dur(input row_t r);
	int d1;
	int tot;
	rate_idx_t di;
	if (r.kind == dur_bcast)
		return '0;
	di = idx_of_code(r.code);
	d1 = 0;
	if (r.resp_len != 0)
		d1 = int'(r.sifs) + airtime(int'(r.resp_len), pick_basic(di, r.brs), r.long_pre);
	tot = d1;
	if (r.next_len != 0)
		tot = 2 * d1 + int'(r.sifs) + airtime(int'(r.next_len), di, r.long_pre);
	return dur_t'(tot);
endfunction

function automatic rate_idx_t model_rate(input row_t r);
	if (r.kind == dur_bcast)
		return '0;
	return pick_basic(idx_of_code(r.code), r.brs);
endfunction

`endif

/* sim/tb_tx_duration.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_tx_duration import dur_pkg::*; ;

	localparam int INV_W  = 16;
	localparam int N_DIR  = 11;
	localparam int N_RAND = 14;
	localparam int N_ROWS = N_DIR + N_RAND;

	logic                 clk;
	logic                 arst_n;
	logic                 start;
	dur_kind_t            dur_kind;
	rate_code_t           data_rate;
	resp_len_t            resp_len;
	frame_len_t           next_len;
	logic                 long_pre;
	logic [NUM_RATES-1:0] basic_rate_set;
	dur_t                 sifs;
	logic                 tab_en;
	rate_idx_t            tab_addr;
	logic [INV_W-1:0]     tab_data;
	logic                 dur_valid;
	dur_t                 dur;
	rate_idx_t            resp_rate;

	`include "tb_dur_model.svh"

	row_t      rows [N_ROWS];
	rate_idx_t rd_addrs [$];
	int        n_checks = 0;
	int        n_errors = 0;
	int        pulse_cnt = 0;

	tx_duration #(.INV_W(INV_W)) dut0 (
		.clk(clk), .arst_n(arst_n), .start(start), .dur_kind(dur_kind),
		.data_rate(data_rate), .resp_len(resp_len), .next_len(next_len),
		.long_pre(long_pre), .basic_rate_set(basic_rate_set), .sifs(sifs),
		.tab_en(tab_en), .tab_addr(tab_addr), .tab_data(tab_data),
		.dur_valid(dur_valid), .dur(dur), .resp_rate(resp_rate)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// rate table, one-cycle read, addresses kept per row
	always @(posedge clk) begin
		if (tab_en) begin
			tab_data <= inv_tab[tab_addr];
			rd_addrs.push_back(tab_addr);
		end
	end

	always @(posedge clk)
		if (dur_valid)
			pulse_cnt = pulse_cnt + 1; // old value, before the DUT updates

	task automatic check_dur(input string name, input dur_t got, input dur_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_rate(input string name, input rate_idx_t got, input rate_idx_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	function automatic row_t make_row(input logic busy, input dur_kind_t k, input rate_code_t c,
		input int rl, input int nl, input logic lp, input logic [NUM_RATES-1:0] brs,
		input int sf, input int ed, input int er);
		row_t r;
		r = '{busy, k, c, resp_len_t'(rl), frame_len_t'(nl), lp, brs, dur_t'(sf),
			dur_t'(ed), rate_idx_t'(er)};
		return r;
	endfunction

	task automatic fill_rows();
		row_t r;
		rows[0]  = make_row(0, dur_bcast, 4'hB, 14, 0, 1, 12'hFFF, 10, 0, 0);
		rows[1]  = make_row(0, dur_single, 4'h3, 0, 0, 0, 12'h150, 16, 0, 4);
		rows[2]  = make_row(0, dur_single, 4'h1, 14, 0, 0, 12'h150, 16, 50, 8);
		rows[3]  = make_row(0, dur_single, 4'h4, 14, 0, 0, 12'h150, 16, 50, 8);
		rows[4]  = make_row(0, dur_single, 4'h0, 14, 0, 0, 12'h00F, 16, 66, 4); // floor
		rows[5]  = make_row(0, dur_single, 4'hB, 14, 0, 1, 12'h003, 10, 258, 1);
		rows[6]  = make_row(0, dur_single, 4'hB, 14, 0, 0, 12'h003, 10, 162, 1);
		rows[7]  = make_row(0, dur_single, 4'hB, 14, 100, 0, 12'h00F, 10, 415, 3);
		rows[8]  = make_row(0, dur_single, 4'h5, 14, 200, 0, 12'h150, 16, 194, 8);
		rows[9]  = make_row(1, dur_single, 4'h1, 14, 0, 0, 12'h150, 16, 50, 8);
		rows[10] = make_row(0, dur_single, 4'h3, 0, 50, 0, 12'h150, 16, 118, 4);
		for (int i = N_DIR; i < N_ROWS; i++) begin
			r.busy = rand_bits(1) == 16'd1;
			r.kind = (rand_bits(3) == 16'd0) ? dur_bcast : dur_single;
			if (rand_bits(1) == 16'd1)
				r.code = rate_code_t'({2'b10, 2'(rand_bits(2))}); // CCK
			else
				r.code = rate_code_t'(rand_bits(3));
			r.resp_len = resp_len_t'(rand_bits(8));
			r.next_len = (rand_bits(1) == 16'd1) ? frame_len_t'(rand_bits(10)) : '0;
			r.long_pre = rand_bits(1) == 16'd1;
			r.brs = NUM_RATES'(rand_bits(NUM_RATES));
			r.sifs = r.code[3] ? dur_t'(10) : dur_t'(16);
			r.exp_dur = model_dur(r);
			r.exp_rate = model_rate(r);
			rows[i] = r;
		end
	endtask

	initial begin
		#((N_ROWS * 20 + 50) * 8);
		$display("timeout: the DUT stopped answering before all rows were applied");
		$display("Test failed");
		$finish;
	end

	initial begin
		int cycles;
		int pulses0;
		int errs0;
		rate_idx_t exp_addrs [$];
		start = 1'b0;
		dur_kind = dur_bcast;
		data_rate = '0;
		resp_len = '0;
		next_len = '0;
		long_pre = 1'b0;
		basic_rate_set = '0;
		sifs = '0;
		tab_data = '0;
		arst_n = 1'b0;
		fill_rows();
		repeat (2) @(posedge clk);
		@(negedge clk);
		if (dur_valid !== 1'b0 || tab_en !== 1'b0) begin
			n_errors++;
			$display("dur_valid or tab_en is not low in reset");
		end
		arst_n = 1'b1;
		for (int i = 0; i < N_ROWS; i++) begin
			@(negedge clk);
			errs0 = n_errors;
			pulses0 = pulse_cnt;
			rd_addrs.delete();
			dur_kind = rows[i].kind;
			data_rate = rows[i].code;
			resp_len = rows[i].resp_len;
			next_len = rows[i].next_len;
			long_pre = rows[i].long_pre;
			basic_rate_set = rows[i].brs;
			sifs = rows[i].sifs;
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;
			cycles = 1;
			while (!dur_valid && cycles < 40) begin
				if (rows[i].busy && cycles == 2) begin
					start = 1'b1; // ignored while busy
					dur_kind = dur_bcast; // a different request if it got through
					resp_len = ~rows[i].resp_len;
					next_len = ~rows[i].next_len;
				end else begin
					start = 1'b0;
				end
				@(negedge clk);
				cycles++;
			end
			start = 1'b0;
			if (!dur_valid) begin
				n_errors++;
				$display("row %0d never raised dur_valid", i);
			end else begin
				check_dur("dur", dur, rows[i].exp_dur);
				check_rate("resp_rate", resp_rate, rows[i].exp_rate);
				if (rows[i].kind == dur_bcast && cycles != 1) begin
					n_errors++;
					$display("row %0d broadcast answer came %0d cycles after start", i, cycles);
				end
			end
			repeat (3) @(negedge clk);
			if (pulse_cnt - pulses0 != 1) begin
				n_errors++;
				$display("row %0d gave %0d dur_valid pulses", i, pulse_cnt - pulses0);
			end
			// response rate read first, then the data rate for the fragment
			exp_addrs.delete();
			if (rows[i].kind == dur_single && rows[i].resp_len != 0)
				exp_addrs.push_back(model_rate(rows[i]));
			if (rows[i].kind == dur_single && rows[i].next_len != 0)
				exp_addrs.push_back(idx_of_code(rows[i].code));
			if (rd_addrs.size() != exp_addrs.size()) begin
				n_errors++;
				$display("row %0d made %0d rate table reads instead of %0d", i,
					rd_addrs.size(), exp_addrs.size());
			end else begin
				foreach (exp_addrs[k])
					check_rate("tab_addr", rd_addrs[k], exp_addrs[k]);
			end
			$display("row %0d dur %0d rate %0d cycles %0d: %s", i, dur, resp_rate, cycles,
				(n_errors == errs0) ? "ok" : "errors");
		end
		$display("%0d rows, %0d checks, %0d errors", N_ROWS, n_checks, n_errors);
		if (n_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* src/basic_rate_sel.sv */
`timescale 1ns/100ps
`default_nettype none

module basic_rate_sel import dur_pkg::*; (
	input  wire rate_idx_t            data_idx,
	input  wire logic [NUM_RATES-1:0] basic_rate_set,
	output rate_idx_t                 resp_idx
);

	rate_idx_t floor_idx;

	// lowest rate of the modulation class, mandatory in every BSS
	assign floor_idx = (data_idx < rate_idx_t'(FIRST_OFDM_IDX)) ?
		rate_idx_t'(0) : rate_idx_t'(FIRST_OFDM_IDX);

	// highest basic rate in [floor, data_idx]
	always_comb begin
		resp_idx = floor_idx;
		for (int i = 0; i < NUM_RATES; i++) begin
			if (basic_rate_set[i] && rate_idx_t'(i) >= floor_idx &&
				rate_idx_t'(i) <= data_idx)
				resp_idx = rate_idx_t'(i); // later hit is faster
		end
	end

endmodule

`default_nettype wire

/* src/dur_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module dur_ctrl import dur_pkg::*; #(
	parameter int INV_W = 16
) (
	input  wire logic             clk,
	input  wire logic             arst_n,
	input  wire logic             start,
	input  wire dur_kind_t        dur_kind,
	input  wire rate_code_t       data_rate,
	input  wire resp_len_t        resp_len,
	input  wire frame_len_t       next_len,
	input  wire logic             long_pre,
	input  wire dur_t             sifs,
	input  wire rate_idx_t        resp_idx,
	output logic                  rd_req,
	output rate_idx_t             rd_idx,
	input  wire logic             rd_ack,
	input  wire logic [INV_W-1:0] inv,
	output logic                  calc,
	output frame_len_t            calc_len,
	output rate_idx_t             calc_idx,
	output logic [INV_W-1:0]      inv_out,
	output logic                  calc_long_pre,
	input  wire logic             air_done,
	input  wire dur_t             air_us,
	output rate_idx_t             data_idx,
	output logic                  dur_valid,
	output dur_t                  dur,
	output rate_idx_t             resp_rate
);

	typedef enum logic [2:0] {
		st_idle,
		st_resp,  // response read, skipped when no ack expected
		st_frag,  // next fragment read, skipped when none follows
		st_wait,  // table read then airtime
		st_done
	} state_t;

	state_t     state;
	logic       frag_ph;   // current airtime belongs to the fragment
	resp_len_t  resp_len_q;
	frame_len_t next_len_q;
	dur_t       sifs_q;
	rate_idx_t  resp_q;
	dur_t       acc;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= st_idle;
			frag_ph   <= 1'b0;
			rd_req    <= 1'b0;
			calc      <= 1'b0;
			dur_valid <= 1'b0;
		end else begin
			rd_req    <= 1'b0;
			calc      <= 1'b0;
			dur_valid <= 1'b0;
			case (state)
				st_idle: begin
					if (start) begin
						if (dur_kind == dur_bcast)
							dur_valid <= 1'b1; // answered right away
						else
							state <= st_resp;
					end
				end
				st_resp: begin
					frag_ph <= 1'b0;
					if (resp_len_q != '0) begin
						rd_req <= 1'b1;
						state  <= st_wait;
					end else begin
						state <= st_frag;
					end
				end
				st_frag: begin
					frag_ph <= 1'b1;
					if (next_len_q != '0) begin
						rd_req <= 1'b1;
						state  <= st_wait;
					end else begin
						state <= st_done;
					end
				end
				st_wait: begin
					if (rd_ack)
						calc <= 1'b1;
					if (air_done)
						state <= frag_ph ? st_done : st_frag;
				end
				default: begin
					dur_valid <= 1'b1;
					state     <= st_idle;
				end
			endcase
		end
	end

	// request fields and the running sum
	always_ff @(posedge clk) begin
		if (state == st_idle && start) begin
			data_idx      <= rate_code_to_index(data_rate);
			resp_len_q    <= resp_len;
			next_len_q    <= next_len;
			calc_long_pre <= long_pre;
			sifs_q        <= sifs;
			if (dur_kind == dur_bcast) begin
				dur       <= '0;
				resp_rate <= '0;
			end
		end
		if (state == st_resp) begin
			resp_q   <= resp_idx; // basic rate settles one cycle after start
			rd_idx   <= resp_idx;
			calc_idx <= resp_idx;
			calc_len <= frame_len_t'(resp_len_q);
			acc      <= '0;
		end
		if (state == st_frag) begin
			rd_idx   <= data_idx;
			calc_idx <= data_idx;
			calc_len <= next_len_q;
			if (next_len_q != '0)
				acc <= (acc << 1) + sifs_q; // 2 x D1 + sifs, airtime added later
		end
		if (state == st_wait) begin
			if (rd_ack)
				inv_out <= inv;
			if (air_done)
				acc <= acc + air_us + (frag_ph ? dur_t'(0) : sifs_q);
		end
		if (state == st_done) begin
			dur       <= acc;
			resp_rate <= resp_q;
		end
	end

endmodule

`default_nettype wire

/* src/dur_pkg.sv */
`default_nettype none

package dur_pkg;

	// hardware rate code, bit 3 flags CCK
	typedef logic [3:0] rate_code_t;

	// dense index, CCK first then OFDM in rising rate order
	typedef logic [3:0] rate_idx_t;

	typedef logic [15:0] dur_t;        // microseconds
	typedef logic [11:0] frame_len_t;  // bytes
	typedef logic [7:0]  resp_len_t;   // bytes

	typedef enum logic {
		dur_bcast  = 1'b0,
		dur_single = 1'b1
	} dur_kind_t;

	localparam int NUM_RATES      = 12;
	localparam int FIRST_OFDM_IDX = 4;

	// OFDM timing
	localparam int OFDM_PREAMBLE_US = 16;
	localparam int OFDM_SIGNAL_US   = 4;
	localparam int OFDM_SYMBOL_US   = 4;
	localparam int SIGNAL_EXT_US    = 6;
	localparam int SERVICE_BITS     = 16;
	localparam int TAIL_BITS        = 6;

	// DSSS/CCK PLCP preamble plus header
	localparam int CCK_LONG_PLCP_US  = 192;
	localparam int CCK_SHORT_PLCP_US = 96;

	localparam int INV_FRAC_BITS = 8; // table word is 1/rate scaled by 256

	function automatic rate_idx_t rate_code_to_index(input rate_code_t code);
		rate_idx_t idx;
		if (code[3]) begin
			idx = rate_idx_t'(code[1:0]); // 1, 2, 5.5, 11
		end else begin
			case (code[2:0])
				3'd0: idx = 4'd10; // 48
				3'd1: idx = 4'd8;  // 24
				3'd2: idx = 4'd6;  // 12
				3'd3: idx = 4'd4;  // 6
				3'd4: idx = 4'd11; // 54
				3'd5: idx = 4'd9;  // 36
				3'd6: idx = 4'd7;  // 18
				default: idx = 4'd5; // 9
			endcase
		end
		return idx;
	endfunction

endpackage

`default_nettype wire

/* src/frame_airtime.sv */
`timescale 1ns/100ps
`default_nettype none

module frame_airtime import dur_pkg::*; #(
	parameter int INV_W = 16
) (
	input  wire logic             clk,
	input  wire logic             arst_n,
	input  wire logic             calc,
	input  wire frame_len_t       len,
	input  wire rate_idx_t        idx,
	input  wire logic [INV_W-1:0] inv,
	input  wire logic             long_pre,
	output logic                  air_done,
	output dur_t                  air_us
);

	localparam int PW = 16 + INV_W;            // bits x inverse rate
	localparam int QW = PW - INV_FRAC_BITS + 1; // quotient plus round-up carry

	logic          is_cck;
	logic [15:0]   nbits;
	logic [PW-1:0] prod;
	logic [QW-1:0] q;
	dur_t          air_nxt;

	assign is_cck = idx < rate_idx_t'(FIRST_OFDM_IDX);

	always_comb begin
		// OFDM carries service and tail bits on top of the PSDU
		if (is_cck)
			nbits = {1'b0, len, 3'b000};
		else
			nbits = 16'(SERVICE_BITS + TAIL_BITS) + {1'b0, len, 3'b000};
		prod = PW'(nbits) * PW'(inv);
		// ceiling of prod / 256
		q = QW'(prod[PW-1:INV_FRAC_BITS]) + QW'(|prod[INV_FRAC_BITS-1:0]);
		if (is_cck) begin
			air_nxt = dur_t'(q) +
				dur_t'(long_pre ? CCK_LONG_PLCP_US : CCK_SHORT_PLCP_US);
		end else begin
			// q is the symbol count here
			air_nxt = dur_t'(OFDM_PREAMBLE_US + OFDM_SIGNAL_US + SIGNAL_EXT_US) +
				dur_t'(q) * dur_t'(OFDM_SYMBOL_US);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			air_done <= 1'b0;
		else
			air_done <= calc;
	end

	always_ff @(posedge clk) begin
		if (calc)
			air_us <= air_nxt;
	end

endmodule

`default_nettype wire

/* src/rate_table_rd.sv */
`timescale 1ns/100ps
`default_nettype none

module rate_table_rd import dur_pkg::*; #(
	parameter int INV_W = 16
) (
	input  wire logic             clk,
	input  wire logic             arst_n,
	input  wire logic             rd_req,
	input  wire rate_idx_t        rd_idx,
	output logic                  tab_en,
	output rate_idx_t             tab_addr,
	input  wire logic [INV_W-1:0] tab_data,
	output logic                  rd_ack,
	output logic [INV_W-1:0]      inv
);

	logic [INV_W-1:0] inv_q;

	// tab_en doubles as the pending flag, data is back the cycle after
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tab_en <= 1'b0;
			rd_ack <= 1'b0;
		end else begin
			tab_en <= rd_req;
			rd_ack <= tab_en;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_req)
			tab_addr <= rd_idx;
		if (rd_ack)
			inv_q <= tab_data; // hold last word
	end

	// word goes out in the return cycle, held copy after that
	assign inv = rd_ack ? tab_data : inv_q;

endmodule

`default_nettype wire

/* src/tx_duration.sv */
`timescale 1ns/100ps
`default_nettype none

module tx_duration import dur_pkg::*; #(
	parameter int INV_W = 16
) (
	input  wire logic                 clk,
	input  wire logic                 arst_n,
	input  wire logic                 start,
	input  wire dur_kind_t            dur_kind,
	input  wire rate_code_t           data_rate,
	input  wire resp_len_t            resp_len,
	input  wire frame_len_t           next_len,
	input  wire logic                 long_pre,
	input  wire logic [NUM_RATES-1:0] basic_rate_set,
	input  wire dur_t                 sifs,
	output logic                      tab_en,
	output rate_idx_t                 tab_addr,
	input  wire logic [INV_W-1:0]     tab_data,
	output logic                      dur_valid,
	output dur_t                      dur,
	output rate_idx_t                 resp_rate
);

	rate_idx_t        data_idx;
	rate_idx_t        resp_idx;
	logic             rd_req;
	rate_idx_t        rd_idx;
	logic             rd_ack;
	logic [INV_W-1:0] inv;
	logic             calc;
	frame_len_t       calc_len;
	rate_idx_t        calc_idx;
	logic [INV_W-1:0] calc_inv;
	logic             calc_long_pre;
	logic             air_done;
	dur_t             air_us;

	dur_ctrl #(.INV_W(INV_W)) ctrl0 (
		.clk(clk), .arst_n(arst_n), .start(start), .dur_kind(dur_kind),
		.data_rate(data_rate), .resp_len(resp_len), .next_len(next_len),
		.long_pre(long_pre), .sifs(sifs), .resp_idx(resp_idx),
		.rd_req(rd_req), .rd_idx(rd_idx), .rd_ack(rd_ack), .inv(inv),
		.calc(calc), .calc_len(calc_len), .calc_idx(calc_idx), .inv_out(calc_inv),
		.calc_long_pre(calc_long_pre), .air_done(air_done), .air_us(air_us),
		.data_idx(data_idx), .dur_valid(dur_valid), .dur(dur), .resp_rate(resp_rate)
	);

	basic_rate_sel sel0 (
		.data_idx(data_idx), .basic_rate_set(basic_rate_set), .resp_idx(resp_idx)
	);

	rate_table_rd #(.INV_W(INV_W)) rd0 (
		.clk(clk), .arst_n(arst_n), .rd_req(rd_req), .rd_idx(rd_idx),
		.tab_en(tab_en), .tab_addr(tab_addr), .tab_data(tab_data),
		.rd_ack(rd_ack), .inv(inv)
	);

	frame_airtime #(.INV_W(INV_W)) air0 (
		.clk(clk), .arst_n(arst_n), .calc(calc), .len(calc_len), .idx(calc_idx),
		.inv(calc_inv), .long_pre(calc_long_pre), .air_done(air_done), .air_us(air_us)
	);

endmodule

`default_nettype wire
